//--- all.f
+incdir+design
design/board_pkg.sv
design/bus_pkg.sv
design/cmd_fifo.sv
design/cmd_ingress.sv
design/playfield_engine.sv
design/tetris_board_top.sv
dv/tb_top.sv

//--- design/board_pkg.sv
`include "tetris_defs.svh"

package board_pkg;

    // locked tile codes
    typedef enum logic [3:0] {
        BLANK   = 4'd0,
        I       = 4'd1,
        O       = 4'd2,
        T       = 4'd3,
        J       = 4'd4,
        L       = 4'd5,
        S       = 4'd6,
        Z       = 4'd7,
        GARBAGE = 4'd8
    } tile_t;

    // column 0 sits in the lowest nibble
    typedef tile_t [`PF_COLS-1:0] pf_row_t;

    typedef logic [4:0] row_idx_t;
    typedef logic [3:0] col_idx_t;
    typedef logic [9:0] line_cnt_t;

    localparam pf_row_t BLANK_ROW = '{`PF_COLS{BLANK}};

endpackage

//--- design/bus_pkg.sv
package bus_pkg;
    import board_pkg::*;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } axil_resp_t;

    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        bready;
        logic        arvalid;
        logic [7:0]  araddr;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        axil_resp_t  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        axil_resp_t  rresp;
    } axil_rsp_t;

    // NOP is rejected at the bus
    typedef enum logic [1:0] {
        OP_NOP         = 2'd0,
        OP_LOCK        = 2'd1,
        OP_GARBAGE     = 2'd2,
        OP_BOARD_RESET = 2'd3
    } cmd_op_t;

    // mask bits 0..3 origin row, bits 4..7 the row below
    typedef struct packed {
        cmd_op_t     op;
        tile_t       tile;
        row_idx_t    row;
        col_idx_t    col;
        logic [7:0]  mask;
        logic [8:0]  pad;
    } lock_cmd_t;

    typedef struct packed {
        cmd_op_t     op;
        col_idx_t    hole;
        logic [2:0]  count;
        logic [22:0] pad;
    } garbage_cmd_t;

    // opcode shares the top bits of both views
    typedef union packed {
        lock_cmd_t    lock;
        garbage_cmd_t garbage;
    } cmd_word_u;

endpackage

//--- design/cmd_fifo.sv
`timescale 1ns/1ps
`include "tetris_defs.svh"

module cmd_fifo
    import bus_pkg::*;
#(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic      clk,
    input  logic      rst_l,
    input  logic      push_valid,
    output logic      push_ready,
    input  cmd_word_u push_cmd,
    output logic      pop_valid,
    input  logic      pop_ready,
    output cmd_word_u pop_cmd,
    output logic      empty
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PW-1:0] LAST_PTR = PW'(DEPTH - 1);
    localparam logic [PW:0]   FULL_CNT = (PW + 1)'(DEPTH);

    cmd_word_u     mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;
    logic          do_push;
    logic          do_pop;

    assign push_ready = count != FULL_CNT;
    assign pop_valid  = count != '0;
    assign empty      = count == '0;
    assign pop_cmd    = mem[rd_ptr];
    assign do_push    = push_valid && push_ready;
    assign do_pop     = pop_valid && pop_ready;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- design/cmd_ingress.sv
`timescale 1ns/1ps
`include "tetris_defs.svh"

module cmd_ingress
    import board_pkg::*, bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_l,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp,
    output logic      push_valid,
    input  logic      push_ready,
    output cmd_word_u push_cmd,
    input  logic      fifo_empty,
    input  logic      engine_idle,
    input  line_cnt_t lines_cleared,
    input  line_cnt_t lines_sent,
    input  logic      top_out,
    output row_idx_t  rd_row,
    input  pf_row_t   rd_row_data
);
    localparam int ROW_END = `ADDR_ROW_BASE + `PF_ROWS * 8;

    cmd_word_u   wr_cmd;
    logic        wr_is_cmd;
    logic        wr_cmd_legal;
    logic        wr_go;
    logic        aw_hs;
    logic        b_hs;
    logic        ar_hs;
    logic        r_hs;
    logic        busy;
    logic        row_hit;
    logic [7:0]  row_off;
    logic [31:0] rd_word;
    logic        rd_ok;

    logic        awready_q;
    logic        wready_q;
    logic        bvalid_q;
    axil_resp_t  bresp_q;
    logic        arready_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    axil_resp_t  rresp_q;

    assign wr_cmd       = axil_req.wdata;
    assign wr_is_cmd    = axil_req.awaddr == `ADDR_CMD;
    assign wr_cmd_legal = wr_is_cmd && (wr_cmd.lock.op != OP_NOP);

    // FIFO slot is checked here, the push lands in the handshake cycle
    assign wr_go = axil_req.awvalid && axil_req.wvalid && !awready_q && !bvalid_q &&
                   (push_ready || !wr_is_cmd);
    assign aw_hs = awready_q && axil_req.awvalid && axil_req.wvalid;
    assign b_hs  = bvalid_q && axil_req.bready;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            awready_q  <= 1'b0;
            wready_q   <= 1'b0;
            push_valid <= 1'b0;
            bvalid_q   <= 1'b0;
            bresp_q    <= OKAY;
        end else begin
            awready_q  <= wr_go;
            wready_q   <= wr_go;
            push_valid <= wr_go && wr_cmd_legal;
            if (aw_hs) begin
                bvalid_q <= 1'b1;
                bresp_q  <= push_valid ? OKAY : SLVERR;
            end else if (b_hs) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            push_cmd <= wr_cmd;
        end
    end

    assign busy    = !fifo_empty || !engine_idle;
    assign row_off = axil_req.araddr - `ADDR_ROW_BASE;
    assign rd_row  = row_off[7:3];
    assign row_hit = (axil_req.araddr >= `ADDR_ROW_BASE) &&
                     (int'(axil_req.araddr) < ROW_END) &&
                     (axil_req.araddr[1:0] == 2'b00);

    always_comb begin
        rd_word = '0;
        rd_ok   = 1'b1;
        if (row_hit) begin
            if (axil_req.araddr[2]) begin
                rd_word = 32'(rd_row_data[`PF_COLS-1:8]);
            end else begin
                rd_word = rd_row_data[7:0];
            end
        end else begin
            case (axil_req.araddr)
                `ADDR_LINES_CLEARED: rd_word = 32'(lines_cleared);
                `ADDR_LINES_SENT:    rd_word = 32'(lines_sent);
                `ADDR_STATUS:        rd_word = {30'd0, top_out, busy};
                default:             rd_ok   = 1'b0;
            endcase
        end
    end

    assign ar_hs = arready_q && axil_req.arvalid;
    assign r_hs  = rvalid_q && axil_req.rready;

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            arready_q <= 1'b1;
            rvalid_q  <= 1'b0;
            rdata_q   <= '0;
            rresp_q   <= OKAY;
        end else if (ar_hs) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b1;
            rdata_q   <= rd_word;
            rresp_q   <= rd_ok ? OKAY : SLVERR;
        end else if (r_hs) begin
            arready_q <= 1'b1;
            rvalid_q  <= 1'b0;
        end
    end

    always_comb begin
        axil_rsp.awready = awready_q;
        axil_rsp.wready  = wready_q;
        axil_rsp.bvalid  = bvalid_q;
        axil_rsp.bresp   = bresp_q;
        axil_rsp.arready = arready_q;
        axil_rsp.rvalid  = rvalid_q;
        axil_rsp.rdata   = rdata_q;
        axil_rsp.rresp   = rresp_q;
    end

endmodule

//--- design/playfield_engine.sv
`timescale 1ns/1ps
`include "tetris_defs.svh"

module playfield_engine
    import board_pkg::*, bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_l,
    input  logic      pop_valid,
    output logic      pop_ready,
    input  cmd_word_u pop_cmd,
    output logic      idle,
    output line_cnt_t lines_cleared,
    output line_cnt_t lines_sent,
    output logic      top_out,
    input  row_idx_t  rd_row,
    output pf_row_t   rd_row_data
);
    typedef enum logic [1:0] {
        IDLE,
        APPLY,
        SCAN,
        SETTLE
    } state_t;

    state_t     state;
    state_t     state_d;
    cmd_word_u  cmd_q;
    logic [2:0] gcnt_q;
    cmd_op_t    op;
    logic       pop_fire;
    pf_row_t    board [`PF_ROWS];
    pf_row_t    garbage_row;
    logic       row_full  [`PF_ROWS];
    logic       row_empty [`PF_ROWS];
    logic       settled;
    logic [4:0] n_full;
    line_cnt_t  attack;
    row_idx_t   lock_r  [8];
    col_idx_t   lock_c  [8];
    logic       lock_ok [8];

    assign op          = cmd_q.lock.op;
    assign pop_fire    = pop_valid && pop_ready;
    assign idle        = state == IDLE;
    assign rd_row_data = (rd_row < `PF_ROWS) ? board[rd_row] : BLANK_ROW;

    always_comb begin
        for (int c = 0; c < `PF_COLS; c++) begin
            garbage_row[c] = (c == int'(cmd_q.garbage.hole)) ? BLANK : GARBAGE;
        end
    end

    // footprint cells, off-board ones dropped
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            lock_r[k]  = row_idx_t'(int'(cmd_q.lock.row) + k / 4);
            lock_c[k]  = col_idx_t'(int'(cmd_q.lock.col) + k % 4);
            lock_ok[k] = cmd_q.lock.mask[k] &&
                         (int'(cmd_q.lock.row) + k / 4 < `PF_ROWS) &&
                         (int'(cmd_q.lock.col) + k % 4 < `PF_COLS);
        end
    end

    always_comb begin
        for (int r = 0; r < `PF_ROWS; r++) begin
            row_full[r]  = 1'b1;
            row_empty[r] = 1'b1;
            for (int c = 0; c < `PF_COLS; c++) begin
                if (board[r][c] == BLANK) begin
                    row_full[r] = 1'b0;
                end else begin
                    row_empty[r] = 1'b0;
                end
            end
        end
    end

    // settled when no blank row sits under a filled one
    always_comb begin
        logic seen;
        seen    = 1'b0;
        settled = 1'b1;
        n_full  = '0;
        for (int r = 0; r < `PF_ROWS; r++) begin
            if (row_empty[r] && seen) begin
                settled = 1'b0;
            end
            if (!row_empty[r]) begin
                seen = 1'b1;
            end
            if (row_full[r]) begin
                n_full = n_full + 5'd1;
            end
        end
    end

    always_comb begin
        case (n_full)
            5'd0, 5'd1: attack = 10'd0;
            5'd2:       attack = 10'd1;
            5'd3:       attack = 10'd2;
            default:    attack = 10'd4;
        endcase
    end

    always_comb begin
        state_d = state;
        case (state)
            IDLE: begin
                if (pop_fire) begin
                    state_d = APPLY;
                end
            end
            APPLY: begin
                if (op == OP_LOCK) begin
                    state_d = SCAN;
                end else if (op != OP_GARBAGE || gcnt_q <= 3'd1) begin
                    state_d = IDLE;
                end
            end
            SCAN:    state_d = SETTLE;
            SETTLE: begin
                if (settled) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            state         <= IDLE;
            pop_ready     <= 1'b0;
            gcnt_q        <= '0;
            lines_cleared <= '0;
            lines_sent    <= '0;
            top_out       <= 1'b0;
        end else begin
            state     <= state_d;
            pop_ready <= state_d == IDLE;
            if (pop_fire) begin
                gcnt_q <= pop_cmd.garbage.count;
            end else if (state == APPLY && gcnt_q != '0) begin
                gcnt_q <= gcnt_q - 3'd1;
            end
            if (state == APPLY && op == OP_BOARD_RESET) begin
                lines_cleared <= '0;
                lines_sent    <= '0;
                top_out       <= 1'b0;
            end
            // a filled top row pushed off the board
            if (state == APPLY && op == OP_GARBAGE && gcnt_q != '0 && !row_empty[0]) begin
                top_out <= 1'b1;
            end
            if (state == SCAN) begin
                lines_cleared <= lines_cleared + line_cnt_t'(n_full);
                lines_sent    <= lines_sent + attack;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_fire) begin
            cmd_q <= pop_cmd;
        end
    end

    always_ff @(posedge clk or negedge rst_l) begin
        if (!rst_l) begin
            for (int r = 0; r < `PF_ROWS; r++) begin
                board[r] <= BLANK_ROW;
            end
        end else begin
            case (state)
                APPLY: begin
                    if (op == OP_LOCK) begin
                        for (int k = 0; k < 8; k++) begin
                            if (lock_ok[k]) begin
                                board[lock_r[k]][lock_c[k]] <= cmd_q.lock.tile;
                            end
                        end
                    end else if (op == OP_GARBAGE && gcnt_q != '0) begin
                        for (int r = 0; r < `PF_ROWS - 1; r++) begin
                            board[r] <= board[r + 1];
                        end
                        board[`PF_ROWS - 1] <= garbage_row;
                    end else if (op == OP_BOARD_RESET) begin
                        for (int r = 0; r < `PF_ROWS; r++) begin
                            board[r] <= BLANK_ROW;
                        end
                    end
                end
                SCAN: begin
                    for (int r = 0; r < `PF_ROWS; r++) begin
                        if (row_full[r]) begin
                            board[r] <= BLANK_ROW;
                        end
                    end
                end
                SETTLE: begin
                    // each blank row pulls the row above down one step
                    if (!settled) begin
                        for (int r = 1; r < `PF_ROWS; r++) begin
                            if (row_empty[r]) begin
                                board[r - 1] <= BLANK_ROW;
                            end
                        end
                        for (int r = 1; r < `PF_ROWS; r++) begin
                            if (row_empty[r]) begin
                                board[r] <= board[r - 1];
                            end
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- design/tetris_board_top.sv
`timescale 1ns/1ps
`include "tetris_defs.svh"

module tetris_board_top
    import board_pkg::*, bus_pkg::*;
(
    input  logic      clk,
    input  logic      rst_l,
    input  axil_req_t axil_req,
    output axil_rsp_t axil_rsp
);
    logic      push_valid;
    logic      push_ready;
    cmd_word_u push_cmd;
    logic      pop_valid;
    logic      pop_ready;
    cmd_word_u pop_cmd;
    logic      fifo_empty;
    logic      engine_idle;
    line_cnt_t lines_cleared;
    line_cnt_t lines_sent;
    logic      top_out;
    row_idx_t  rd_row;
    pf_row_t   rd_row_data;

    cmd_ingress ingress_inst (
        .clk           (clk),
        .rst_l         (rst_l),
        .axil_req      (axil_req),
        .axil_rsp      (axil_rsp),
        .push_valid    (push_valid),
        .push_ready    (push_ready),
        .push_cmd      (push_cmd),
        .fifo_empty    (fifo_empty),
        .engine_idle   (engine_idle),
        .lines_cleared (lines_cleared),
        .lines_sent    (lines_sent),
        .top_out       (top_out),
        .rd_row        (rd_row),
        .rd_row_data   (rd_row_data)
    );

    cmd_fifo #(
        .DEPTH (`FIFO_DEPTH)
    ) fifo_inst (
        .clk        (clk),
        .rst_l      (rst_l),
        .push_valid (push_valid),
        .push_ready (push_ready),
        .push_cmd   (push_cmd),
        .pop_valid  (pop_valid),
        .pop_ready  (pop_ready),
        .pop_cmd    (pop_cmd),
        .empty      (fifo_empty)
    );

    playfield_engine engine_inst (
        .clk           (clk),
        .rst_l         (rst_l),
        .pop_valid     (pop_valid),
        .pop_ready     (pop_ready),
        .pop_cmd       (pop_cmd),
        .idle          (engine_idle),
        .lines_cleared (lines_cleared),
        .lines_sent    (lines_sent),
        .top_out       (top_out),
        .rd_row        (rd_row),
        .rd_row_data   (rd_row_data)
    );

endmodule

//--- design/tetris_defs.svh
`ifndef TETRIS_DEFS_SVH
`define TETRIS_DEFS_SVH

// playfield geometry, row 0 at the top
`define PF_ROWS 20
`define PF_COLS 10

// command FIFO entries
`define FIFO_DEPTH 4

// AXI4-Lite register map
`define ADDR_CMD           8'h00
`define ADDR_LINES_CLEARED 8'h04
`define ADDR_LINES_SENT    8'h08
`define ADDR_STATUS        8'h0C

// two words per row
// lo word at row*8 holds columns 0 to 7, column 0 in the low nibble
// hi word at row*8+4 holds columns 8 and 9 in its low byte
`define ADDR_ROW_BASE      8'h40

`endif

//--- dv/tb_top.sv
`timescale 1ns/1ps
`include "tetris_defs.svh"

module tb_top
    import board_pkg::*, bus_pkg::*;
();
    localparam int NUM_TESTS      = 5;
    localparam int TEST_BUDGET_NS = 20000;

    logic      clk;
    logic      rst_l;
    axil_req_t req;
    axil_rsp_t rsp;

    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr_state = 32'h1eb6_11a0;

    // reference board and counters
    pf_row_t   model_board [`PF_ROWS];
    line_cnt_t model_cleared;
    line_cnt_t model_sent;
    logic      model_top;

    tetris_board_top dut (
        .clk      (clk),
        .rst_l    (rst_l),
        .axil_req (req),
        .axil_rsp (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * TEST_BUDGET_NS);
        $display("timeout: the tests did not finish within %0d ns", NUM_TESTS * TEST_BUDGET_NS);
        $display("ERRORS FOUND");
        $finish;
    end

    // one galois step per bit
    function automatic logic lfsr_bit();
        logic b;
        b          = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [7:0] lfsr_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_bit();
        end
        return v;
    endfunction

    task automatic clear_reference();
        for (int r = 0; r < `PF_ROWS; r++) begin
            model_board[r] = BLANK_ROW;
        end
        model_cleared = '0;
        model_sent    = '0;
        model_top     = 1'b0;
    endtask

    task automatic garbage_reference(input col_idx_t hole, input logic [2:0] count);
        pf_row_t fresh;
        for (int c = 0; c < `PF_COLS; c++) begin
            fresh[c] = (c == int'(hole)) ? BLANK : GARBAGE;
        end
        for (int i = 0; i < int'(count); i++) begin
            if (model_board[0] != BLANK_ROW) begin
                model_top = 1'b1;
            end
            for (int r = 0; r < `PF_ROWS - 1; r++) begin
                model_board[r] = model_board[r + 1];
            end
            model_board[`PF_ROWS - 1] = fresh;
        end
    endtask

    task automatic lock_reference(input tile_t tile, input row_idx_t row, input col_idx_t col,
                                  input logic [7:0] mask);
        pf_row_t stacked [`PF_ROWS];
        int      rr;
        int      cc;
        int      n;
        int      w;
        logic    full;
        for (int k = 0; k < 8; k++) begin
            rr = int'(row) + k / 4;
            cc = int'(col) + k % 4;
            if (mask[k] && rr < `PF_ROWS && cc < `PF_COLS) begin
                model_board[rr][cc] = tile;
            end
        end
        n = 0;
        for (int r = 0; r < `PF_ROWS; r++) begin
            full = 1'b1;
            for (int c = 0; c < `PF_COLS; c++) begin
                if (model_board[r][c] == BLANK) begin
                    full = 1'b0;
                end
            end
            if (full) begin
                n++;
                model_board[r] = BLANK_ROW;
            end
        end
        model_cleared = model_cleared + line_cnt_t'(n);
        case (n)
            2:       model_sent = model_sent + 10'd1;
            3:       model_sent = model_sent + 10'd2;
            4:       model_sent = model_sent + 10'd4;
            default: model_sent = model_sent;
        endcase
        // settled board stacks the non-blank rows in order on the floor
        w = `PF_ROWS - 1;
        for (int r = `PF_ROWS - 1; r >= 0; r--) begin
            if (model_board[r] != BLANK_ROW) begin
                stacked[w] = model_board[r];
                w--;
            end
        end
        for (int r = w; r >= 0; r--) begin
            stacked[r] = BLANK_ROW;
        end
        for (int r = 0; r < `PF_ROWS; r++) begin
            model_board[r] = stacked[r];
        end
    endtask

    task automatic check_resp(input string what, input axil_resp_t got, input axil_resp_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s returned resp %0d, expected %0d",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input line_cnt_t got, input line_cnt_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_row(input row_idx_t r, input pf_row_t got, input pf_row_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: row %0d reads %h, expected %h", $time, r, got, exp);
        end
    endtask

    task automatic check_status(input logic [1:0] got, input logic [1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: status top_out/busy %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input int stall, output axil_resp_t resp);
        @(posedge clk);
        #2;
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        req.wstrb   = 4'hf;
        @(negedge clk);
        while (!(rsp.awready && rsp.wready)) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        @(negedge clk);
        while (!rsp.bvalid) begin
            @(negedge clk);
        end
        resp = rsp.bresp;
        // response has to wait for bready
        repeat (stall + 1) @(posedge clk);
        #2;
        if (!rsp.bvalid) begin
            errors++;
            $display("write response to address %h dropped before bready at %0t ns",
                     addr, $time);
        end
        req.bready = 1'b1;
        @(posedge clk);
        #2;
        req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output axil_resp_t resp);
        @(posedge clk);
        #2;
        req.arvalid = 1'b1;
        req.araddr  = addr;
        @(negedge clk);
        while (!rsp.arready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req.arvalid = 1'b0;
        @(negedge clk);
        while (!rsp.rvalid) begin
            @(negedge clk);
        end
        data = rsp.rdata;
        resp = rsp.rresp;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        axil_resp_t  resp;
        st = 32'h1;
        while (st[0]) begin
            axil_read(`ADDR_STATUS, st, resp);
        end
    endtask

    // full comparison of status, counters and every row half
    task automatic compare_all();
        logic [31:0] lo;
        logic [31:0] hi;
        axil_resp_t  resp;
        wait_idle();
        axil_read(`ADDR_STATUS, lo, resp);
        check_resp("status read", resp, OKAY);
        check_status(lo[1:0], {model_top, 1'b0});
        axil_read(`ADDR_LINES_CLEARED, lo, resp);
        check_resp("lines_cleared read", resp, OKAY);
        check_count("lines_cleared", line_cnt_t'(lo[9:0]), model_cleared);
        axil_read(`ADDR_LINES_SENT, lo, resp);
        check_resp("lines_sent read", resp, OKAY);
        check_count("lines_sent", line_cnt_t'(lo[9:0]), model_sent);
        for (int r = 0; r < `PF_ROWS; r++) begin
            axil_read(8'(`ADDR_ROW_BASE + r * 8), lo, resp);
            check_resp("row lo read", resp, OKAY);
            axil_read(8'(`ADDR_ROW_BASE + r * 8 + 4), hi, resp);
            check_resp("row hi read", resp, OKAY);
            check_row(row_idx_t'(r), pf_row_t'({hi[7:0], lo}), model_board[r]);
        end
    endtask

    task automatic send_lock(input tile_t tile, input row_idx_t row, input col_idx_t col,
                             input logic [7:0] mask, input int stall);
        lock_cmd_t  lc;
        cmd_word_u  word;
        axil_resp_t resp;
        lc        = '0;
        lc.op     = OP_LOCK;
        lc.tile   = tile;
        lc.row    = row;
        lc.col    = col;
        lc.mask   = mask;
        word.lock = lc;
        axil_write(`ADDR_CMD, word, stall, resp);
        check_resp("lock command", resp, OKAY);
        lock_reference(tile, row, col, mask);
    endtask

    task automatic send_garbage(input col_idx_t hole, input logic [2:0] count, input int stall);
        garbage_cmd_t gc;
        cmd_word_u    word;
        axil_resp_t   resp;
        gc           = '0;
        gc.op        = OP_GARBAGE;
        gc.hole      = hole;
        gc.count     = count;
        word.garbage = gc;
        axil_write(`ADDR_CMD, word, stall, resp);
        check_resp("garbage command", resp, OKAY);
        garbage_reference(hole, count);
    endtask

    task automatic send_reset();
        cmd_word_u  word;
        axil_resp_t resp;
        word         = '0;
        word.lock.op = OP_BOARD_RESET;
        axil_write(`ADDR_CMD, word, 0, resp);
        check_resp("board reset command", resp, OKAY);
        clear_reference();
    endtask

    task automatic report_test(input int num, input string name, input int errors_at_start);
        $display("test %0d %s finished with %0d errors", num, name, errors - errors_at_start);
    endtask

    task automatic test_bus_basics();
        int          start;
        logic [31:0] data;
        axil_resp_t  resp;
        start = errors;
        compare_all();
        axil_write(8'h10, 32'h1234_5678, 0, resp);
        check_resp("unmapped write", resp, SLVERR);
        axil_write(`ADDR_CMD, 32'h0, 0, resp);
        check_resp("nop command", resp, SLVERR);
        axil_read(8'h20, data, resp);
        check_resp("unmapped read", resp, SLVERR);
        checks++;
        if (data !== 32'h0) begin
            errors++;
            $display("mismatch at %0t ns: unmapped read data %h, expected 0", $time, data);
        end
        compare_all();
        report_test(1, "reset state and bus errors", start);
    endtask

    task automatic test_single_lock();
        int          start;
        logic [31:0] st;
        axil_resp_t  resp;
        start = errors;
        send_lock(T, 5'd9, 4'd3, 8'h27, 0);
        // piece still dropping to the floor right after the write response
        axil_read(`ADDR_STATUS, st, resp);
        check_status(st[1:0], {model_top, 1'b1});
        compare_all();
        report_test(2, "single T lock", start);
    endtask

    task automatic test_line_clears();
        int start;
        start = errors;
        send_reset();
        // two-cell marker that rides on top of the cleared rows
        send_lock(J, 5'd10, 4'd0, 8'h11, 0);
        for (int n = 1; n <= 4; n++) begin
            send_garbage(4'd9, 3'd1, 0);
            if (n > 1) begin
                // hole column past the board gives rows with no gap
                send_garbage(4'd15, 3'(n - 1), 0);
            end
            send_lock(L, row_idx_t'(20 - n), 4'd9, 8'h01, 0);
            compare_all();
        end
        report_test(3, "one to four line clears", start);
    endtask

    task automatic test_garbage_top_out();
        int start;
        start = errors;
        send_garbage(4'd3, 3'd2, 0);
        send_garbage(4'd7, 3'd1, 0);
        compare_all();
        send_garbage(4'd0, 3'd7, 0);
        send_garbage(4'd5, 3'd7, 0);
        send_garbage(4'd8, 3'd7, 0);
        compare_all();
        send_reset();
        compare_all();
        report_test(4, "garbage rows, top out and board reset", start);
    endtask

    task automatic test_random_stream();
        int         start;
        int         stall;
        logic [2:0] cnt;
        tile_t      tile;
        start = errors;
        for (int i = 0; i < 8; i++) begin
            stall = (i % 2 == 1) ? 3 : 0;
            if (lfsr_bit()) begin
                col_idx_t hole;
                hole = col_idx_t'(lfsr_bits(4) % 8'd10);
                cnt  = 3'(lfsr_bits(3));
                if (cnt == 3'd0) begin
                    cnt = 3'd1;
                end
                send_garbage(hole, cnt, stall);
            end else begin
                tile = tile_t'(4'(lfsr_bits(3) % 8'd7 + 8'd1));
                send_lock(tile, row_idx_t'(lfsr_bits(5) % 8'd20),
                          col_idx_t'(lfsr_bits(4) % 8'd10), lfsr_bits(8), stall);
            end
        end
        compare_all();
        report_test(5, "random command stream with bready stalls", start);
    endtask

    initial begin
        rst_l      = 1'b0;
        req        = '0;
        req.rready = 1'b1;
        clear_reference();
        repeat (10) @(posedge clk);
        #2;
        rst_l = 1'b1;

        test_bus_basics();
        test_single_lock();
        test_line_clears();
        test_garbage_top_out();
        test_random_stream();

        $display("run complete: %0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_top -f all.f --Mdir build -o tb_sim
./build/tb_sim | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
